// ==== logic/istore_cfg.svh ====
// Instruction store sizing
// Core count, store depth and instruction width shared by all blocks

`ifndef ISTORE_CFG_SVH
`define ISTORE_CFG_SVH

// Cores, one private store each
`define ISTORE_NUM_CORES 4
`define ISTORE_CORE_BITS 2

// Words per store and word address width
`define ISTORE_DEPTH 64
`define ISTORE_ADDR_BITS $clog2(`ISTORE_DEPTH)

// Host address is bank select above word address
`define ISTORE_BUS_ADDR_BITS (`ISTORE_CORE_BITS + `ISTORE_ADDR_BITS)

// Instruction word
`define ISTORE_WORD_BITS 32
`define ISTORE_LEN_BITS 8

`endif

// ==== logic/istore_pkg.sv ====
// Instruction store types
// Burst kinds, bank request, instruction word views and decoded fetch

`default_nettype none
`include "istore_cfg.svh"

package istore_pkg;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_t;

    // Loader request, broadcast to every bank
    typedef struct packed {
        logic [`ISTORE_CORE_BITS-1:0] bank;
        logic [`ISTORE_ADDR_BITS-1:0] addr;
        logic                         wr_en;
        logic                         rd_en;
        logic [`ISTORE_WORD_BITS-1:0] wr_data;
    } bank_req_t;

    // ------------------------------------------------------------
    // Instruction word, two encodings over the same 32 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] dest;
        logic [7:0] src_a;
        logic [7:0] src_b;
    } alu_fields_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  dest;
        logic [15:0] imm;      // Signed constant
    } ldc_fields_t;

    typedef union packed {
        alu_fields_t alu;
        ldc_fields_t ldc;
    } istore_word_t;

    localparam logic [7:0] OPC_LDC = 8'hF0;

    typedef struct packed {
        logic        is_ldc;
        logic [7:0]  opcode;
        logic [7:0]  dest;
        logic [31:0] operand_a;  // Extended src_a or immediate
        logic [7:0]  operand_b;
    } fetch_dec_t;

endpackage

`default_nettype wire

// ==== logic/istore_loader.sv ====
// Instruction store loader
// Turns host write bursts and readback requests into bank requests,
// generating fixed, incrementing and wrapping burst addresses

`timescale 1ns/1ps
`default_nettype none
`include "istore_cfg.svh"

module istore_loader (
    input  wire                              clock_in,
    input  wire                              reset_in,
    input  wire                              burst_start,
    input  wire [`ISTORE_BUS_ADDR_BITS-1:0]  burst_addr,
    input  wire [`ISTORE_LEN_BITS-1:0]       burst_len,
    input  wire istore_pkg::burst_t          burst_kind,
    input  wire                              wr_strobe,
    input  wire [`ISTORE_WORD_BITS-1:0]      wr_data,
    input  wire                              rd_req,
    input  wire [`ISTORE_BUS_ADDR_BITS-1:0]  rd_addr,
    output logic                             busy,
    output istore_pkg::bank_req_t            bank_req,
    output logic                             rd_pending,
    output logic [`ISTORE_CORE_BITS-1:0]     rd_bank
);

    import istore_pkg::*;

    logic [`ISTORE_CORE_BITS-1:0] wr_bank;
    logic [`ISTORE_ADDR_BITS-1:0] wr_addr;
    logic [`ISTORE_ADDR_BITS-1:0] addr_inc;
    logic [`ISTORE_ADDR_BITS-1:0] wr_addr_next;
    logic [`ISTORE_ADDR_BITS-1:0] wrap_mask;
    logic [`ISTORE_LEN_BITS-1:0]  len_q;
    logic [`ISTORE_LEN_BITS-1:0]  word_cnt;
    burst_t                       kind_q;
    logic                         wr_fire;
    logic                         rd_en_q;
    logic [`ISTORE_CORE_BITS-1:0] rd_bank_q;
    logic [`ISTORE_ADDR_BITS-1:0] rd_addr_q;

    assign wr_fire   = wr_strobe && busy;   // Strobes only count inside a burst
    assign addr_inc  = wr_addr + {{(`ISTORE_ADDR_BITS-1){1'b0}}, 1'b1};
    assign wrap_mask = len_q[`ISTORE_ADDR_BITS-1:0];  // len+1 is a power of two

    // ------------------------------------------------------------
    // Next write address per burst kind
    // ------------------------------------------------------------
    always_comb begin
        case (kind_q)
            burst_incr: wr_addr_next = addr_inc;   // Rolls over at depth
            burst_wrap: wr_addr_next = (wr_addr & ~wrap_mask) | (addr_inc & wrap_mask);
            default:    wr_addr_next = wr_addr;
        endcase
    end

    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            busy     <= 1'b0;
            word_cnt <= '0;
            rd_en_q  <= 1'b0;
        end else begin
            rd_en_q <= rd_req;
            if (burst_start) begin
                busy     <= 1'b1;
                word_cnt <= '0;
            end else if (wr_fire) begin
                word_cnt <= word_cnt + {{(`ISTORE_LEN_BITS-1){1'b0}}, 1'b1};
                if (word_cnt == len_q)
                    busy <= 1'b0;                   // Last word of the burst
            end
        end
    end

    // Burst and read address latches
    always_ff @(posedge clock_in) begin
        if (burst_start) begin
            wr_bank <= burst_addr[`ISTORE_BUS_ADDR_BITS-1 -: `ISTORE_CORE_BITS];
            wr_addr <= burst_addr[`ISTORE_ADDR_BITS-1:0];
            len_q   <= burst_len;
            kind_q  <= burst_kind;
        end else if (wr_fire) begin
            wr_addr <= wr_addr_next;
        end
        if (rd_req) begin
            rd_bank_q <= rd_addr[`ISTORE_BUS_ADDR_BITS-1 -: `ISTORE_CORE_BITS];
            rd_addr_q <= rd_addr[`ISTORE_ADDR_BITS-1:0];
        end
    end

    // Reads never overlap a burst, so the address mux is safe
    always_comb begin
        bank_req.bank    = rd_en_q ? rd_bank_q : wr_bank;
        bank_req.addr    = rd_en_q ? rd_addr_q : wr_addr;
        bank_req.wr_en   = wr_fire;
        bank_req.rd_en   = rd_en_q;
        bank_req.wr_data = wr_data;
    end

    assign rd_pending = rd_en_q;
    assign rd_bank    = rd_bank_q;

endmodule

`default_nettype wire

// ==== logic/istore_bank.sv ====
// Instruction store bank
// One core's dual-port program memory. Port A serves host writes and
// readback, port B serves the core's fetch every cycle

`timescale 1ns/1ps
`default_nettype none
`include "istore_cfg.svh"

module istore_bank (
    input  wire                           clock_in,
    input  wire istore_pkg::bank_req_t    bank_req,
    input  wire [`ISTORE_ADDR_BITS-1:0]   fetch_addr,
    output logic [`ISTORE_WORD_BITS-1:0]  bus_word,
    output logic [`ISTORE_WORD_BITS-1:0]  fetch_word
);

    logic [`ISTORE_WORD_BITS-1:0] mem [`ISTORE_DEPTH];

    // ------------------------------------------------------------
    // Port A, host side
    // ------------------------------------------------------------
    // Enables arrive already qualified for this bank
    always_ff @(posedge clock_in) begin
        if (bank_req.wr_en)
            mem[bank_req.addr] <= bank_req.wr_data;
        if (bank_req.rd_en)
            bus_word <= mem[bank_req.addr];     // Holds until next read
    end

    // ------------------------------------------------------------
    // Port B, core fetch
    // ------------------------------------------------------------
    // Registered read, one cycle from address to word
    always_ff @(posedge clock_in) begin
        fetch_word <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

// ==== logic/istore_readout.sv ====
// Instruction store readout
// Returns the host readback word and decodes every core's fetched word
// as either an ALU or a load-constant instruction

`timescale 1ns/1ps
`default_nettype none
`include "istore_cfg.svh"

module istore_readout (
    input  wire                                                 clock_in,
    input  wire                                                 reset_in,
    input  wire [`ISTORE_NUM_CORES-1:0][`ISTORE_WORD_BITS-1:0]  bus_words,
    input  wire [`ISTORE_NUM_CORES-1:0][`ISTORE_WORD_BITS-1:0]  fetch_words,
    input  wire                                                 rd_pending,
    input  wire [`ISTORE_CORE_BITS-1:0]                         rd_bank,
    output logic                                                rd_valid,
    output logic [`ISTORE_WORD_BITS-1:0]                        rd_data,
    output istore_pkg::fetch_dec_t                              fetch_out [`ISTORE_NUM_CORES]
);

    import istore_pkg::*;

    logic [`ISTORE_CORE_BITS-1:0] rd_bank_q;

    // ------------------------------------------------------------
    // Host readback
    // ------------------------------------------------------------
    always_ff @(posedge clock_in) begin
        if (!reset_in)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_pending;
    end

    always_ff @(posedge clock_in) begin
        rd_bank_q <= rd_bank;       // Aligns with the bank's registered word
    end

    assign rd_data = bus_words[rd_bank_q];

    // ------------------------------------------------------------
    // Fetch decode, one per core
    // ------------------------------------------------------------
    for (genvar c = 0; c < `ISTORE_NUM_CORES; c++) begin : g_dec
        istore_word_t word_view;

        assign word_view = fetch_words[c];

        always_comb begin
            fetch_out[c].is_ldc = (word_view.ldc.opcode == OPC_LDC);
            fetch_out[c].opcode = word_view.alu.opcode;
            fetch_out[c].dest   = word_view.alu.dest;
            if (word_view.ldc.opcode == OPC_LDC) begin
                // Immediate sign-extended to full width
                fetch_out[c].operand_a = {{16{word_view.ldc.imm[15]}}, word_view.ldc.imm};
                fetch_out[c].operand_b = 8'h00;
            end else begin
                fetch_out[c].operand_a = {24'h000000, word_view.alu.src_a};
                fetch_out[c].operand_b = word_view.alu.src_b;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/istore_array.sv ====
// Instruction store array, top level
// Host loader, one private store per core and the readback/decode stage

`timescale 1ns/1ps
`default_nettype none
`include "istore_cfg.svh"

module istore_array (
    input  wire                                                 clock_in,
    input  wire                                                 reset_in,
    input  wire                                                 burst_start,
    input  wire [`ISTORE_BUS_ADDR_BITS-1:0]                     burst_addr,
    input  wire [`ISTORE_LEN_BITS-1:0]                          burst_len,
    input  wire istore_pkg::burst_t                             burst_kind,
    input  wire                                                 wr_strobe,
    input  wire [`ISTORE_WORD_BITS-1:0]                         wr_data,
    input  wire                                                 rd_req,
    input  wire [`ISTORE_BUS_ADDR_BITS-1:0]                     rd_addr,
    output logic                                                busy,
    output logic                                                rd_valid,
    output logic [`ISTORE_WORD_BITS-1:0]                        rd_data,
    input  wire [`ISTORE_NUM_CORES-1:0][`ISTORE_ADDR_BITS-1:0]  fetch_addr,
    output istore_pkg::fetch_dec_t                              fetch_out [`ISTORE_NUM_CORES]
);

    import istore_pkg::*;

    bank_req_t                                          bank_req;
    logic                                               rd_pending;
    logic [`ISTORE_CORE_BITS-1:0]                       rd_bank;
    logic [`ISTORE_NUM_CORES-1:0][`ISTORE_WORD_BITS-1:0] bus_words;
    logic [`ISTORE_NUM_CORES-1:0][`ISTORE_WORD_BITS-1:0] fetch_words;

    istore_loader u_loader (
        .clock_in    (clock_in),
        .reset_in    (reset_in),
        .burst_start (burst_start),
        .burst_addr  (burst_addr),
        .burst_len   (burst_len),
        .burst_kind  (burst_kind),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .busy        (busy),
        .bank_req    (bank_req),
        .rd_pending  (rd_pending),
        .rd_bank     (rd_bank)
    );

    // ------------------------------------------------------------
    // One bank per core, selected by its loop index
    // ------------------------------------------------------------
    for (genvar i = 0; i < `ISTORE_NUM_CORES; i++) begin : g_bank
        bank_req_t bank_req_local;
        logic      hit;

        assign hit = (bank_req.bank == i[`ISTORE_CORE_BITS-1:0]);
        assign bank_req_local = '{bank:    bank_req.bank,
                                  addr:    bank_req.addr,
                                  wr_en:   bank_req.wr_en && hit,
                                  rd_en:   bank_req.rd_en && hit,
                                  wr_data: bank_req.wr_data};

        istore_bank u_bank (
            .clock_in   (clock_in),
            .bank_req   (bank_req_local),
            .fetch_addr (fetch_addr[i]),
            .bus_word   (bus_words[i]),
            .fetch_word (fetch_words[i])
        );
    end

    istore_readout u_readout (
        .clock_in    (clock_in),
        .reset_in    (reset_in),
        .bus_words   (bus_words),
        .fetch_words (fetch_words),
        .rd_pending  (rd_pending),
        .rd_bank     (rd_bank),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .fetch_out   (fetch_out)
    );

endmodule

`default_nettype wire

// ==== tests/istore_checker.sv ====
// Instruction store protocol checks
// Bound into the array top, watches readback timing and burst strobes

`timescale 1ns/1ps
`default_nettype none

module istore_checker (
    input wire clock_in,
    input wire reset_in,
    input wire burst_start,
    input wire busy,
    input wire rd_req,
    input wire rd_valid
);

    int violations = 0;     // Read by the testbench watchdog

    // Readback answers exactly two cycles after the request
    rd_latency: assert property (@(posedge clock_in) disable iff (!reset_in)
        $past(rd_req, 2) |-> rd_valid)
        else begin $error("rd_valid missing two cycles after rd_req"); violations++; end

    rd_no_spurious: assert property (@(posedge clock_in) disable iff (!reset_in)
        rd_valid |-> $past(rd_req, 2))
        else begin $error("rd_valid without a matching rd_req"); violations++; end

    burst_when_idle: assert property (@(posedge clock_in) disable iff (!reset_in)
        burst_start |-> !busy)
        else begin $error("burst_start while busy"); violations++; end

    busy_reset: assert property (@(posedge clock_in) !reset_in |=> !busy)
        else begin $error("busy high after reset"); violations++; end

endmodule

bind istore_array istore_checker u_checker (
    .clock_in    (clock_in),
    .reset_in    (reset_in),
    .burst_start (burst_start),
    .busy        (busy),
    .rd_req      (rd_req),
    .rd_valid    (rd_valid)
);

`default_nettype wire

// ==== tests/istore_tb.sv ====
// Instruction store array testbench
// Replays burst, readback and fetch commands from a data file, keeps a
// reference copy of every store and checks the DUT against it

`timescale 1ns/1ps
`default_nettype none
`include "istore_cfg.svh"

module istore_tb;

    import istore_pkg::*;

    localparam int CORES      = `ISTORE_NUM_CORES;
    localparam int DEPTH      = `ISTORE_DEPTH;
    localparam int STIM_WORDS = 512;

    logic                                                clock_in;
    logic                                                reset_in;
    logic                                                burst_start;
    logic [`ISTORE_BUS_ADDR_BITS-1:0]                    burst_addr;
    logic [`ISTORE_LEN_BITS-1:0]                         burst_len;
    burst_t                                              burst_kind;
    logic                                                wr_strobe;
    logic [`ISTORE_WORD_BITS-1:0]                        wr_data;
    logic                                                rd_req;
    logic [`ISTORE_BUS_ADDR_BITS-1:0]                    rd_addr;
    logic                                                busy;
    logic                                                rd_valid;
    logic [`ISTORE_WORD_BITS-1:0]                        rd_data;
    logic [`ISTORE_NUM_CORES-1:0][`ISTORE_ADDR_BITS-1:0] fetch_addr;
    fetch_dec_t                                          fetch_out [CORES];

    logic [31:0]      stim       [STIM_WORDS];
    logic [31:0]      ref_mem    [CORES][DEPTH];   // Expected store contents
    logic             written    [CORES][DEPTH];
    logic [31:0]      burst_data [DEPTH];
    logic [5:0]       pend_addr  [CORES];          // One pending fetch slot per core
    fetch_dec_t       exp_fetch  [CORES];
    logic [CORES-1:0] pend_mask;
    integer           seed;
    int               ptr;
    int               cycle_count;
    int               cycle_limit;

    istore_array UUT (
        .clock_in    (clock_in),
        .reset_in    (reset_in),
        .burst_start (burst_start),
        .burst_addr  (burst_addr),
        .burst_len   (burst_len),
        .burst_kind  (burst_kind),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .busy        (busy),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .fetch_addr  (fetch_addr),
        .fetch_out   (fetch_out)
    );

    initial begin
        clock_in = 1'b0;
        forever #50 clock_in = ~clock_in;
    end

    // ------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        abort_run();
    endtask

    task automatic report_problem(input string text);
        $display("Error at %0t ns: %s", $time, text);
        abort_run();
    endtask

    // Watchdog that also picks up failures of the bound checker
    always @(posedge clock_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
            report_problem("the test did not finish within the cycle limit");
        else if (UUT.u_checker.violations != 0)
            report_problem("a protocol assertion in the bound checker failed");
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic [5:0] next_addr(input logic [5:0] addr, input logic [7:0] len,
                                             input logic [1:0] kind);
        int a;
        int block;
        int base;
        a     = int'(addr);
        block = int'(len) + 1;
        case (kind)
            2'd1: a = (a + 1) % DEPTH;
            2'd2: begin
                base = a - (a % block);               // Aligned block start
                a    = base + ((a - base + 1) % block);
            end
            default: ;                                // Fixed keeps the address
        endcase
        return a[5:0];
    endfunction

    function automatic fetch_dec_t decode_word(input logic [31:0] w);
        fetch_dec_t d;
        d.opcode = w[31:24];
        d.dest   = w[23:16];
        d.is_ldc = (w[31:24] == 8'hF0);
        if (d.is_ldc) begin
            d.operand_a = {{16{w[15]}}, w[15:0]};
            d.operand_b = 8'h00;
        end else begin
            d.operand_a = {24'h000000, w[15:8]};
            d.operand_b = w[7:0];
        end
        return d;
    endfunction

    // First written address at or above start keeps random fetches off empty words
    function automatic logic [5:0] pick_written(input int core, input logic [5:0] start);
        logic [5:0] a;
        logic       found;
        a     = start;
        found = 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            if (!found) begin
                if (written[core][a])
                    found = 1'b1;
                else
                    a = a + 6'd1;
            end
        end
        return a;
    endfunction

    function automatic int count_commands();
        int p;
        int n;
        p = 0;
        n = 0;
        while (p < STIM_WORDS && stim[p] !== 32'd0) begin
            case (stim[p])
                32'd1:   p = p + 6 + int'(stim[p+3][7:0]);
                32'd2:   p = p + 3;
                32'd3:   p = p + 8;
                32'd4:   p = p + 5;
                default: p = STIM_WORDS;
            endcase
            n++;
        end
        return n;
    endfunction

    // ------------------------------------------------------------
    // Bus and fetch sequences driven on the falling edge
    // ------------------------------------------------------------
    task automatic load_burst(input logic [1:0] bank, input logic [5:0] addr,
                              input logic [7:0] len, input logic [1:0] kind);
        logic [5:0] a;
        a           = addr;
        burst_start = 1'b1;
        burst_addr  = {bank, addr};
        burst_len   = len;
        burst_kind  = burst_t'(kind);
        @(negedge clock_in);
        burst_start = 1'b0;
        assert (busy === 1'b1) else report_problem("busy did not rise after burst_start");
        for (int i = 0; i <= int'(len); i++) begin
            wr_strobe = 1'b1;
            wr_data   = burst_data[i];
            ref_mem[bank][a] = burst_data[i];
            written[bank][a] = 1'b1;
            a = next_addr(a, len, kind);
            @(negedge clock_in);
        end
        wr_strobe = 1'b0;
        while (busy) @(negedge clock_in);           // Watchdog bounds this wait
    endtask

    task automatic read_back(input logic [7:0] bus_addr, input logic [31:0] expected);
        int wait_cycles;
        assert (expected === ref_mem[bus_addr[7:6]][bus_addr[5:0]])
            else report_problem("test data read value disagrees with the reference memory");
        rd_req  = 1'b1;
        rd_addr = bus_addr;
        @(negedge clock_in);
        rd_req      = 1'b0;
        wait_cycles = 1;
        while (rd_valid !== 1'b1 && wait_cycles < 10) begin
            @(negedge clock_in);
            wait_cycles++;
        end
        assert (rd_valid === 1'b1) else report_problem("no rd_valid within 10 cycles of rd_req");
        assert (wait_cycles == 2)
            else report_mismatch("rd_valid latency", 64'(wait_cycles), 64'd2);
        assert (rd_data === expected)
            else report_mismatch("read data", {32'd0, rd_data}, {32'd0, expected});
        @(negedge clock_in);
    endtask

    // Issues all pending fetches in one cycle and checks them one cycle later
    task automatic fetch_batch();
        for (int c = 0; c < CORES; c++) begin
            if (pend_mask[c])
                fetch_addr[c] = pend_addr[c];
        end
        @(negedge clock_in);
        for (int c = 0; c < CORES; c++) begin
            if (pend_mask[c])
                assert (fetch_out[c] === exp_fetch[c])
                    else report_mismatch($sformatf("fetch decode on core %0d", c),
                                         {7'd0, fetch_out[c]}, {7'd0, exp_fetch[c]});
        end
        pend_mask = '0;
    endtask

    task automatic random_phase(input logic [1:0] bank, input logic [5:0] addr,
                                input logic [7:0] len, input int rounds);
        logic [31:0] r;
        for (int i = 0; i <= int'(len); i++) begin
            r = $random(seed);
            if (r[0])
                r[31:24] = 8'hF0;                   // Mix in load-constant words
            burst_data[i] = r;
        end
        load_burst(bank, addr, len, 2'd1);
        for (int n = 0; n < rounds; n++) begin
            for (int c = 0; c < CORES; c++) begin
                r            = $random(seed);
                pend_addr[c] = pick_written(c, r[5:0]);
                exp_fetch[c] = decode_word(ref_mem[c][pend_addr[c]]);
                pend_mask[c] = 1'b1;
            end
            fetch_batch();
        end
    endtask

    // ------------------------------------------------------------
    // Command replay
    // ------------------------------------------------------------
    initial begin
        int   c;
        logic done;
        seed        = 58817;
        cycle_count = 0;
        reset_in    = 1'b0;
        burst_start = 1'b0;
        burst_addr  = '0;
        burst_len   = '0;
        burst_kind  = burst_fixed;
        wr_strobe   = 1'b0;
        wr_data     = '0;
        rd_req      = 1'b0;
        rd_addr     = '0;
        fetch_addr  = '0;
        pend_mask   = '0;
        for (int k = 0; k < CORES; k++)
            for (int a = 0; a < DEPTH; a++)
                written[k][a] = 1'b0;
        $readmemh("tests/istore_testdata.mem", stim);
        cycle_limit = count_commands() * 40 + 200;

        repeat (4) @(negedge clock_in);
        reset_in = 1'b1;
        @(negedge clock_in);
        assert (busy === 1'b0 && rd_valid === 1'b0)
            else report_problem("busy or rd_valid is high after reset");

        ptr  = 0;
        done = 1'b0;
        while (!done) begin
            case (stim[ptr])
                32'd0: done = 1'b1;
                32'd1: begin
                    for (int i = 0; i <= int'(stim[ptr+3][7:0]); i++)
                        burst_data[i] = stim[ptr+5+i];
                    load_burst(stim[ptr+1][1:0], stim[ptr+2][5:0], stim[ptr+3][7:0],
                               stim[ptr+4][1:0]);
                    ptr = ptr + 6 + int'(stim[ptr+3][7:0]);
                end
                32'd2: begin
                    read_back(stim[ptr+1][7:0], stim[ptr+2]);
                    ptr = ptr + 3;
                end
                32'd3: begin
                    c = int'(stim[ptr+1][1:0]);
                    if (pend_mask[c])
                        fetch_batch();              // Same core twice starts a new batch
                    pend_addr[c]           = stim[ptr+2][5:0];
                    exp_fetch[c].is_ldc    = stim[ptr+3][0];
                    exp_fetch[c].opcode    = stim[ptr+4][7:0];
                    exp_fetch[c].dest      = stim[ptr+5][7:0];
                    exp_fetch[c].operand_a = stim[ptr+6];
                    exp_fetch[c].operand_b = stim[ptr+7][7:0];
                    assert (decode_word(ref_mem[c][pend_addr[c]]) === exp_fetch[c])
                        else report_problem("test data fetch fields disagree with the reference");
                    pend_mask[c] = 1'b1;
                    ptr = ptr + 8;
                    if (stim[ptr] !== 32'd3)
                        fetch_batch();
                end
                32'd4: begin
                    random_phase(stim[ptr+1][1:0], stim[ptr+2][5:0], stim[ptr+3][7:0],
                                 int'(stim[ptr+4]));
                    ptr = ptr + 5;
                end
                default: report_problem("unknown command tag in the test data");
            endcase
        end

        if (UUT.u_checker.violations == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_problem("a protocol assertion in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

// ==== tests/istore_testdata.mem ====
// Tags: 1 burst (bank addr len kind data...), 2 read (bus_addr expected),
// 3 fetch (core addr is_ldc opcode dest operand_a operand_b), 4 random (bank addr len rounds), 0 end
// Incrementing burst into each bank
1 0 00 3 1 01020304 F0051234 F007FFFE 2A0B0C0D
1 1 10 2 1 10111213 F00A8000 33445566
1 2 20 1 1 F00C7FFF 44010203
1 3 30 1 1 55AABBCC F00D0001
// Readback of every word written so far
2 00 01020304
2 01 F0051234
2 02 F007FFFE
2 03 2A0B0C0D
2 50 10111213
2 51 F00A8000
2 52 33445566
2 A0 F00C7FFF
2 A1 44010203
2 F0 55AABBCC
2 F1 F00D0001
// Fixed burst over a prepared run, only its last word stays
1 0 07 2 1 07070707 08080808 09090909
1 0 08 2 0 AAAA0001 AAAA0002 AAAA0003
2 07 07070707
2 08 AAAA0003
2 09 09090909
// Wrap burst from the middle of block 4..7, then incr across the top
1 1 06 3 2 66000006 77000007 44000004 55000005
2 44 44000004
2 45 55000005
2 46 66000006
2 47 77000007
1 2 3F 1 1 3F3F3F3F 00C0FFEE
2 BF 3F3F3F3F
2 80 00C0FFEE
// Same-cycle fetches on all cores
3 0 01 1 F0 05 00001234 00
3 1 11 1 F0 0A FFFF8000 00
3 2 21 0 44 01 00000002 03
3 3 30 0 55 AA 000000BB CC
3 0 02 1 F0 07 FFFFFFFE 00
3 1 10 0 10 11 00000012 13
3 2 20 1 F0 0C 00007FFF 00
3 3 31 1 F0 0D 00000001 00
3 0 00 0 01 02 00000003 04
// Random loads, then fetches checked against the reference memory
4 2 10 0F 8
4 0 20 1F 8
0

// ==== flist.f ====
+incdir+logic
logic/istore_pkg.sv
logic/istore_loader.sv
logic/istore_bank.sv
logic/istore_readout.sv
logic/istore_array.sv
tests/istore_checker.sv
tests/istore_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instruction store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module istore_tb \
    -f flist.f --Mdir obj_dir -o istore_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/istore_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
